// ==== hw/cpu_word_pkg.sv ====
//==========================================================================
// machine word types: data words, addresses, register numbers, byte masks
//==========================================================================

`default_nettype none

package cpu_word_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;
    localparam int REG_W  = 5;    // 32 general registers
    localparam int WEN_W  = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;

    // instruction address, kseg1 boot space after reset
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [REG_W-1:0]  reg_idx_t;

    typedef logic [WEN_W-1:0]  wen_t;    // one bit per byte lane

endpackage

`default_nettype wire

// ==== hw/hazard_ctrl.sv ====
//==========================================================================
// stall and flush priority, pc write/select and per-stage write and flush
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_settings.svh"

module hazard_ctrl (
    input  logic                    icache_busy,
    input  logic                    dcache_busy,
    input  logic                    dh_stall,       // data hazard seen in ID
    input  logic                    exe_redirect,   // taken branch resolved in EXE
    input  logic                    mem_exception,
    input  logic                    mem_eret,
    output logic                    pc_wr,
    output logic                    pc_sel_vector,
    output logic                    pc_sel_epc,
    output logic                    pc_sel_target,
    output logic [`FRONT_DEPTH-1:0] front_wr,
    output logic [`FRONT_DEPTH-1:0] front_flush,
    output logic [`BACK_DEPTH-1:0]  back_wr,
    output logic [`BACK_DEPTH-1:0]  back_flush,
    output logic                    wb_wr,
    output logic                    wb_flush
);

    localparam int IF_IDX  = 0;
    localparam int ID_IDX  = 1;
    localparam int EXE_IDX = `FRONT_DEPTH - 1;

    pipe_entry_pkg::stage_ctrl_t ctrl;

    // first match wins, default is everything advancing
    always_comb begin
        ctrl          = '0;
        ctrl.front_wr = '1;
        ctrl.back_wr  = '1;
        ctrl.wb_wr    = 1'b1;
        pc_wr         = 1'b1;
        pc_sel_vector = 1'b0;
        pc_sel_epc    = 1'b0;
        pc_sel_target = 1'b0;

        if (mem_exception || mem_eret) begin
            // kill the MEM instruction and all younger ones
            pc_sel_vector    = mem_exception;
            pc_sel_epc       = !mem_exception;
            ctrl.front_flush = '1;
            ctrl.back_flush  = '1;
            ctrl.wb_flush    = 1'b1;
        end else if (dcache_busy) begin
            pc_wr         = 1'b0;    // whole pipe frozen
            ctrl.front_wr = '0;
            ctrl.back_wr  = '0;
            ctrl.wb_wr    = 1'b0;
        end else if (exe_redirect) begin
            // delay slot moves ID to EXE, the two fetches behind it are wrong path
            pc_sel_target            = 1'b1;
            ctrl.front_flush[IF_IDX] = 1'b1;
            ctrl.front_flush[ID_IDX] = 1'b1;
        end else if (dh_stall) begin
            pc_wr                     = 1'b0;
            ctrl.front_wr[IF_IDX]     = 1'b0;
            ctrl.front_wr[ID_IDX]     = 1'b0;
            ctrl.front_flush[EXE_IDX] = 1'b1;    // bubble into EXE
        end else if (icache_busy) begin
            pc_wr                    = 1'b0;
            ctrl.front_wr[IF_IDX]    = 1'b0;
            ctrl.front_flush[ID_IDX] = 1'b1;
        end
    end

    assign front_wr    = ctrl.front_wr;
    assign front_flush = ctrl.front_flush;
    assign back_wr     = ctrl.back_wr;
    assign back_flush  = ctrl.back_flush;
    assign wb_wr       = ctrl.wb_wr;
    assign wb_flush    = ctrl.wb_flush;

endmodule

`default_nettype wire

// ==== hw/mips_pipe_trace_top.sv ====
//==========================================================================
// pipeline top: pc generator, front and back stage chains, controller, trace
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_settings.svh"

module mips_pipe_trace_top (
    input  logic                   aclk,
    input  logic                   arst_n,
    input  logic                   icache_busy,
    input  logic                   dcache_busy,
    input  logic                   dh_stall,
    input  logic                   exe_redirect,
    input  cpu_word_pkg::addr_t    exe_target,
    input  logic                   mem_exception,
    input  logic                   mem_eret,
    input  cpu_word_pkg::addr_t    cp0_epc,
    input  cpu_word_pkg::reg_idx_t exe_dst,       // what EXE would compute
    input  cpu_word_pkg::word_t    exe_result,
    input  logic                   exe_rf_wr,
    output cpu_word_pkg::addr_t    debug_wb_pc,
    output cpu_word_pkg::word_t    debug_wb_rf_wdata,
    output cpu_word_pkg::wen_t     debug_wb_rf_wen,
    output cpu_word_pkg::reg_idx_t debug_wb_rf_wnum
);

    logic                         pc_wr;
    logic                         pc_sel_vector;
    logic                         pc_sel_epc;
    logic                         pc_sel_target;
    wire pipe_entry_pkg::stage_ctrl_t ctrl;    // write/flush for every register

    pipe_entry_pkg::fetch_entry_t fetch;
    pipe_entry_pkg::fetch_entry_t front_stages [`FRONT_DEPTH];    // IF, ID, EXE
    pipe_entry_pkg::wb_entry_t    exe_entry;
    pipe_entry_pkg::wb_entry_t    mem_stages [`BACK_DEPTH];

    hazard_ctrl u_hazard_ctrl (
        .icache_busy   (icache_busy),
        .dcache_busy   (dcache_busy),
        .dh_stall      (dh_stall),
        .exe_redirect  (exe_redirect),
        .mem_exception (mem_exception),
        .mem_eret      (mem_eret),
        .pc_wr         (pc_wr),
        .pc_sel_vector (pc_sel_vector),
        .pc_sel_epc    (pc_sel_epc),
        .pc_sel_target (pc_sel_target),
        .front_wr      (ctrl.front_wr),
        .front_flush   (ctrl.front_flush),
        .back_wr       (ctrl.back_wr),
        .back_flush    (ctrl.back_flush),
        .wb_wr         (ctrl.wb_wr),
        .wb_flush      (ctrl.wb_flush)
    );

    pc_gen u_pc_gen (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .pc_wr         (pc_wr),
        .pc_sel_vector (pc_sel_vector),
        .pc_sel_epc    (pc_sel_epc),
        .pc_sel_target (pc_sel_target),
        .cp0_epc       (cp0_epc),
        .exe_target    (exe_target),
        .fetch         (fetch)
    );

    stage_chain #(
        .entry_t (pipe_entry_pkg::fetch_entry_t),
        .DEPTH   (`FRONT_DEPTH)
    ) u_front_chain (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .wr      (ctrl.front_wr),
        .flush   (ctrl.front_flush),
        .din     (fetch),
        .stages  (front_stages)
    );

    // EXE outcome joins the pc carried down the front end
    assign exe_entry = '{valid:  front_stages[`FRONT_DEPTH-1].valid,
                         pc:     front_stages[`FRONT_DEPTH-1].pc,
                         dst:    exe_dst,
                         result: exe_result,
                         rf_wr:  exe_rf_wr};

    stage_chain #(
        .entry_t (pipe_entry_pkg::wb_entry_t),
        .DEPTH   (`BACK_DEPTH)
    ) u_back_chain (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .wr      (ctrl.back_wr),
        .flush   (ctrl.back_flush),
        .din     (exe_entry),
        .stages  (mem_stages)
    );

    wb_trace u_wb_trace (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .wb_wr             (ctrl.wb_wr),
        .wb_flush          (ctrl.wb_flush),
        .mem_entry         (mem_stages[`BACK_DEPTH-1]),    // last back stage is MEM
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

// ==== hw/pc_gen.sv ====
//==========================================================================
// program counter register and next-pc select, drives the fetch entry
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_settings.svh"

module pc_gen (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic                         pc_wr,          // pc advances or loads this edge
    input  logic                         pc_sel_vector,  // MEM exception
    input  logic                         pc_sel_epc,     // eret back to epc
    input  logic                         pc_sel_target,  // taken branch from EXE
    input  cpu_word_pkg::addr_t          cp0_epc,
    input  cpu_word_pkg::addr_t          exe_target,
    output pipe_entry_pkg::fetch_entry_t fetch
);

    cpu_word_pkg::addr_t pc;
    cpu_word_pkg::addr_t pc_next;

    // select lines are one-hot from the controller, vector first anyway
    always_comb begin
        if (pc_sel_vector) begin
            pc_next = `EXC_VECTOR;
        end else if (pc_sel_epc) begin
            pc_next = cp0_epc;
        end else if (pc_sel_target) begin
            pc_next = exe_target;
        end else begin
            pc_next = pc + `PC_STEP;    // sequential fetch
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (pc_wr) begin
            pc <= pc_next;
        end
    end

    // a fetch is presented every cycle, IF write decides if it is taken
    assign fetch = '{valid: 1'b1, pc: pc};

endmodule

`default_nettype wire

// ==== hw/pipe_entry_pkg.sv ====
//==========================================================================
// pipeline entries held by the stage registers, per-stage control vectors
//==========================================================================

`default_nettype none

`include "pipe_settings.svh"

package pipe_entry_pkg;

    // what the front end carries, IF through EXE
    typedef struct packed {
        logic                valid;
        cpu_word_pkg::addr_t pc;
    } fetch_entry_t;

    // EXE result on its way to write-back
    typedef struct packed {
        logic                   valid;
        cpu_word_pkg::addr_t    pc;
        cpu_word_pkg::reg_idx_t dst;      // destination register
        cpu_word_pkg::word_t    result;
        logic                   rf_wr;    // instruction writes the register file
    } wb_entry_t;

    // write and flush pattern for every stage register
    typedef struct packed {
        logic [`FRONT_DEPTH-1:0] front_wr;
        logic [`FRONT_DEPTH-1:0] front_flush;
        logic [`BACK_DEPTH-1:0]  back_wr;
        logic [`BACK_DEPTH-1:0]  back_flush;
        logic                    wb_wr;
        logic                    wb_flush;
    } stage_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/pipe_settings.svh ====
//==========================================================================
// reset and exception vectors, pc step, stage counts, trace write mask
//==========================================================================

`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// fetch address after reset
`define RESET_PC    32'hBFC0_0000
// general exception entry
`define EXC_VECTOR  32'hBFC0_0380
`define PC_STEP     32'd4

// IF, ID and EXE registers
`define FRONT_DEPTH 3
`define BACK_DEPTH  1   // MEM only

`define WB_WEN_ALL  4'b1111

`endif

// ==== hw/stage_chain.sv ====
//==========================================================================
// chain of stage registers over any entry type, per-stage write and flush
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module stage_chain #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 1
) (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic [DEPTH-1:0] wr,      // bit i loads stage i from its predecessor
    input  logic [DEPTH-1:0] flush,   // bit i loads a bubble, wins over wr
    input  entry_t           din,     // feeds stage 0
    output entry_t           stages [DEPTH]
);

    entry_t src [DEPTH];    // what each stage would load

    // stage 0 takes the chain input, the rest take the stage in front
    always_comb begin
        src[0] = din;
        for (int i = 1; i < DEPTH; i++) begin
            src[i] = stages[i-1];
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (flush[i]) begin
                    stages[i] <= '0;         // bubble, valid bit low
                end else if (wr[i]) begin
                    stages[i] <= src[i];
                end
                // otherwise hold
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/wb_trace.sv ====
//==========================================================================
// write-back register and golden-trace debug outputs
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_settings.svh"

module wb_trace (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      wb_wr,
    input  logic                      wb_flush,
    input  pipe_entry_pkg::wb_entry_t mem_entry,
    output cpu_word_pkg::addr_t       debug_wb_pc,
    output cpu_word_pkg::word_t       debug_wb_rf_wdata,
    output cpu_word_pkg::wen_t        debug_wb_rf_wen,
    output cpu_word_pkg::reg_idx_t    debug_wb_rf_wnum
);

    pipe_entry_pkg::wb_entry_t wb_entry;
    logic                      fresh;    // entry loaded on the last edge

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_entry <= '0;
            fresh    <= 1'b0;
        end else if (wb_flush) begin
            wb_entry <= '0;
            fresh    <= 1'b0;
        end else if (wb_wr) begin
            wb_entry <= mem_entry;
            fresh    <= 1'b1;
        end else begin
            fresh    <= 1'b0;    // held entry, already reported
        end
    end

    assign debug_wb_pc       = wb_entry.pc;
    assign debug_wb_rf_wdata = wb_entry.result;
    assign debug_wb_rf_wnum  = wb_entry.dst;
    // one report per instruction
    assign debug_wb_rf_wen   = (wb_entry.valid && wb_entry.rf_wr && fresh) ? `WB_WEN_ALL : '0;

endmodule

`default_nettype wire

// ==== mips_pipe_trace.f ====
+incdir+hw
hw/cpu_word_pkg.sv
hw/pipe_entry_pkg.sv
hw/pc_gen.sv
hw/stage_chain.sv
hw/hazard_ctrl.sv
hw/wb_trace.sv
hw/mips_pipe_trace_top.sv
tests/mips_pipe_props.sv
tests/tb_mips_pipe_trace.sv

// ==== tests/mips_pipe_props.sv ====
//==========================================================================
// write-enable properties on the debug trace, bound into the pipeline top
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_settings.svh"

module mips_pipe_props (
    input logic               aclk,
    input logic               arst_n,
    input logic               dcache_busy,
    input cpu_word_pkg::wen_t debug_wb_rf_wen
);

    int violation_count = 0;

    // all byte lanes or none
    wen_full_or_none: assert property (@(posedge aclk)
        debug_wb_rf_wen == '0 || debug_wb_rf_wen == `WB_WEN_ALL)
        else begin
            violation_count++;
            $error("debug_wb_rf_wen carries a partial mask %b", debug_wb_rf_wen);
        end

    wen_quiet_in_reset: assert property (@(posedge aclk)
        !arst_n |-> debug_wb_rf_wen == '0)
        else begin
            violation_count++;
            $error("debug_wb_rf_wen is set while reset is asserted");
        end

    // a frozen WB entry was already reported
    wen_quiet_after_freeze: assert property (@(posedge aclk) disable iff (!arst_n)
        $past(dcache_busy) |-> debug_wb_rf_wen == '0)
        else begin
            violation_count++;
            $error("write reported again after a dcache_busy cycle");
        end

endmodule

bind mips_pipe_trace_top mips_pipe_props u_props (
    .aclk            (aclk),
    .arst_n          (arst_n),
    .dcache_busy     (dcache_busy),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

`default_nettype wire

// ==== tests/pipe_golden.txt ====
// one line per cycle after reset: icache dcache dh_stall redirect target exception eret epc
// exe_dst exe_result exe_rf_wr, then expected debug pc, wdata, wen, wnum for that cycle
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 01 C0DE0001 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 02 C0DE0002 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 03 C0DE0003 0  BFC00000 C0DE0001 F 01
0 0 1 0 00000000 0 0 00000000 04 C0DE0004 1  BFC00004 C0DE0002 F 02  // data hazard
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC00008 C0DE0003 0 03
1 0 0 0 00000000 0 0 00000000 05 C0DE0005 1  BFC0000C C0DE0004 F 04  // icache miss
0 0 0 0 00000000 0 0 00000000 06 C0DE0006 1  00000000 00000000 0 00
0 1 0 0 00000000 0 0 00000000 00 00000000 0  BFC00010 C0DE0005 F 05  // dcache freeze
0 1 0 0 00000000 0 0 00000000 00 00000000 0  BFC00010 C0DE0005 0 05
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC00010 C0DE0005 0 05
0 0 0 1 BFC01000 0 0 00000000 07 C0DE0007 1  BFC00014 C0DE0006 F 06  // branch taken
0 0 0 0 00000000 0 0 00000000 08 C0DE0008 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC00018 C0DE0007 F 07
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC0001C C0DE0008 F 08
0 0 1 1 BFC02000 0 0 00000000 09 C0DE0009 1  00000000 00000000 0 00  // branch beats hazard
0 0 0 0 00000000 0 0 00000000 0A C0DE000A 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC01000 C0DE0009 F 09
0 0 0 0 00000000 0 0 00000000 00 00000000 0  BFC01004 C0DE000A F 0A
0 0 0 0 00000000 0 0 00000000 0B C0DE000B 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 0C C0DE000C 1  00000000 00000000 0 00
0 0 0 0 00000000 1 0 00000000 0D C0DE000D 1  BFC02000 C0DE000B F 0B  // exception in MEM
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 0E C0DE000E 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 0F C0DE000F 1  00000000 00000000 0 00
0 0 0 0 00000000 0 1 BFC02004 10 C0DE0010 1  BFC00380 C0DE000E F 0E  // eret
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 00 00000000 0  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 11 C0DE0011 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 12 C0DE0012 1  00000000 00000000 0 00
0 0 0 0 00000000 0 0 00000000 13 C0DE0013 1  BFC02004 C0DE0011 F 11
0 0 0 0 00000000 0 0 00000000 14 C0DE0014 1  BFC02008 C0DE0012 F 12

// ==== tests/tb_mips_pipe_trace.sv ====
//==========================================================================
// testbench: golden-file stimulus, trace compare tasks, timeout, verdict
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_mips_pipe_trace;

    localparam int GOLDEN_LINES = 37;
    localparam int FIELDS       = 15;    // values per golden line
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = GOLDEN_LINES + RESET_CYCLES + 20;

    logic                   aclk;
    logic                   arst_n;
    logic                   icache_busy;
    logic                   dcache_busy;
    logic                   dh_stall;
    logic                   exe_redirect;
    cpu_word_pkg::addr_t    exe_target;
    logic                   mem_exception;
    logic                   mem_eret;
    cpu_word_pkg::addr_t    cp0_epc;
    cpu_word_pkg::reg_idx_t exe_dst;
    cpu_word_pkg::word_t    exe_result;
    logic                   exe_rf_wr;
    cpu_word_pkg::addr_t    debug_wb_pc;
    cpu_word_pkg::word_t    debug_wb_rf_wdata;
    cpu_word_pkg::wen_t     debug_wb_rf_wen;
    cpu_word_pkg::reg_idx_t debug_wb_rf_wnum;

    logic [31:0] golden [GOLDEN_LINES*FIELDS];
    int          cycle_count = 0;

    mips_pipe_trace_top uut (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .icache_busy       (icache_busy),
        .dcache_busy       (dcache_busy),
        .dh_stall          (dh_stall),
        .exe_redirect      (exe_redirect),
        .exe_target        (exe_target),
        .mem_exception     (mem_exception),
        .mem_eret          (mem_eret),
        .cp0_epc           (cp0_epc),
        .exe_dst           (exe_dst),
        .exe_result        (exe_result),
        .exe_rf_wr         (exe_rf_wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #50 aclk = ~aclk;    // 100 ns period

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_addr(input string name, input cpu_word_pkg::addr_t expected,
                                input cpu_word_pkg::addr_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail at %0t ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic compare_word(input string name, input cpu_word_pkg::word_t expected,
                                input cpu_word_pkg::word_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail at %0t ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic compare_wen(input string name, input cpu_word_pkg::wen_t expected,
                               input cpu_word_pkg::wen_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail at %0t ns: %s expected %b, actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic compare_reg_idx(input string name, input cpu_word_pkg::reg_idx_t expected,
                                   input cpu_word_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail at %0t ns: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
        end
    endtask

    // inputs for one cycle, called right after a rising edge
    task automatic drive_line(input int idx);
        int base;
        base = idx * FIELDS;
        icache_busy   <= golden[base][0];
        dcache_busy   <= golden[base+1][0];
        dh_stall      <= golden[base+2][0];
        exe_redirect  <= golden[base+3][0];
        exe_target    <= golden[base+4];
        mem_exception <= golden[base+5][0];
        mem_eret      <= golden[base+6][0];
        cp0_epc       <= golden[base+7];
        exe_dst       <= golden[base+8][4:0];
        exe_result    <= golden[base+9];
        exe_rf_wr     <= golden[base+10][0];
    endtask

    task automatic check_line(input int idx);
        int base;
        base = idx * FIELDS;
        compare_addr("debug_wb_pc", golden[base+11], debug_wb_pc);
        compare_word("debug_wb_rf_wdata", golden[base+12], debug_wb_rf_wdata);
        compare_wen("debug_wb_rf_wen", golden[base+13][3:0], debug_wb_rf_wen);
        compare_reg_idx("debug_wb_rf_wnum", golden[base+14][4:0], debug_wb_rf_wnum);
        if (uut.u_props.violation_count != 0) begin
            fail_stop("a trace property in mips_pipe_props was violated");
        end
    endtask

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_stop($sformatf("timeout: the run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        aclk          = 1'b0;
        arst_n        = 1'b0;
        icache_busy   = 1'b0;
        dcache_busy   = 1'b0;
        dh_stall      = 1'b0;
        exe_redirect  = 1'b0;
        exe_target    = '0;
        mem_exception = 1'b0;
        mem_eret      = 1'b0;
        cp0_epc       = '0;
        exe_dst       = '0;
        exe_result    = '0;
        exe_rf_wr     = 1'b0;
        $readmemh("tests/pipe_golden.txt", golden);
        if ($isunknown(golden[0]) || $isunknown(golden[GOLDEN_LINES*FIELDS-1])) begin
            fail_stop("golden file tests/pipe_golden.txt is missing or too short");
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
        for (int idx = 0; idx < GOLDEN_LINES; idx++) begin
            drive_line(idx);
            @(negedge aclk);    // outputs settled mid-cycle
            check_line(idx);
            @(posedge aclk);
        end
        @(negedge aclk);    // properties sampled on the last edge
        if (uut.u_props.violation_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_stop("a trace property in mips_pipe_props was violated");
        end
    end

endmodule

`default_nettype wire
